// ==== sim.f ====
hdl/pcie_rx_pkg.sv
hdl/rx_beat_register.sv
hdl/cpld_unpacker.sv
hdl/mem_req_decoder.sv
hdl/cmd_fifo.sv
hdl/reg_cmd_issuer.sv
hdl/pcie_rx.sv
tests/tb_pcie_rx.sv

// ==== Makefile ====
# Verilator build and run of the PCIe receive splitter testbench

VERILATOR ?= verilator
TOP       := tb_pcie_rx
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails when the testbench fails"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_pcie_rx.sv ====
// PCIe receive splitter testbench
// Drives a table of TLPs, checks download words and register commands
// against values built from the table, with a small register-block model

`timescale 1ns/100ps

module tb_pcie_rx;
    import pcie_rx_pkg::*;

    // ========================================
    // stimulus table
    // ========================================
    localparam logic [2:0] kind_cpld    = 3'd0;    // completion with data
    localparam logic [2:0] kind_rd      = 3'd1;    // bar0 mem read, 32-bit addr
    localparam logic [2:0] kind_wr      = 3'd2;    // bar0 mem write, 32-bit addr
    localparam logic [2:0] kind_wr_nbar = 3'd3;    // mem write outside bar0
    localparam logic [2:0] kind_req64   = 3'd4;    // 64-bit addr write

    localparam int num_rows      = 13;
    localparam int drain_timeout = 2000;           // cycles
    localparam int idle_tail     = 40;

    typedef struct packed {
        logic [2:0]  kind;
        logic [2:0]  tc;
        logic [1:0]  attr;
        logic [9:0]  len;          // header length field
        logic [15:0] id;           // requester or completer id
        logic [7:0]  tag;
        logic [7:0]  be;
        logic [11:0] byte_cnt;
        logic [31:0] addr;
        logic        gap;          // idle cycles inside the packet
    } tlp_row_t;

    localparam tlp_row_t stim_table [num_rows] = '{
        '{kind_cpld,    3'd0, 2'b00, 10'd4, 16'h0100, 8'h11, 8'h00, 12'd16, 32'h0,  1'b0},
        '{kind_wr,      3'd0, 2'b00, 10'd1, 16'h0008, 8'h01, 8'h0f, 12'd0,  32'h10, 1'b0},
        '{kind_rd,      3'd1, 2'b00, 10'd1, 16'h0008, 8'h02, 8'h0f, 12'd0,  32'h20, 1'b0},
        '{kind_rd,      3'd0, 2'b10, 10'd1, 16'h0008, 8'h03, 8'h0f, 12'd0,  32'h24, 1'b0},
        '{kind_rd,      3'd0, 2'b01, 10'd1, 16'h0010, 8'h04, 8'h03, 12'd0,  32'h28, 1'b0},
        '{kind_wr_nbar, 3'd0, 2'b00, 10'd1, 16'h0008, 8'h05, 8'h0f, 12'd0,  32'h30, 1'b0},
        '{kind_req64,   3'd0, 2'b00, 10'd1, 16'h0008, 8'h06, 8'h0f, 12'd0,  32'h34, 1'b0},
        '{kind_cpld,    3'd2, 2'b00, 10'd6, 16'h0100, 8'h5a, 8'h00, 12'd24, 32'h0,  1'b1},
        '{kind_wr,      3'd0, 2'b00, 10'd2, 16'h0008, 8'h07, 8'hff, 12'd0,  32'h40, 1'b1},
        '{kind_cpld,    3'd0, 2'b01, 10'd2, 16'h0100, 8'h77, 8'h00, 12'd8,  32'h0,  1'b0},
        '{kind_rd,      3'd0, 2'b00, 10'd1, 16'h0008, 8'h08, 8'hf0, 12'd0,  32'h44, 1'b1},
        '{kind_cpld,    3'd0, 2'b00, 10'd8, 16'h0100, 8'h3c, 8'h00, 12'd32, 32'h0,  1'b1},
        '{kind_wr,      3'd7, 2'b11, 10'd1, 16'h0008, 8'h09, 8'h0f, 12'd0,  32'h80, 1'b0}
    };

    typedef struct packed {
        logic        is_sop;       // header event, else data word
        logic        eop;
        logic [63:0] data;
        logic [7:0]  tag;
        logic [11:0] dcnt;
    } cpld_event_t;

    // ========================================
    // DUT signals and checker state
    // ========================================
    logic         PCIE_CLK    = 1'b0;
    logic         PCIE_RST    = 1'b1;
    logic [63:0]  rx_tdata    = '0;
    logic [7:0]   rx_tkeep    = '0;
    logic         rx_tlast    = 1'b0;
    logic         rx_tvalid   = 1'b0;
    logic         rx_bar0_hit = 1'b0;
    logic         reg_rd_ok   = 1'b0;
    cpld_stream_t cpld;
    logic         reg_wr_req;
    logic         reg_rd_req;
    logic [31:0]  reg_addr;
    logic [31:0]  reg_wr_data;
    reg_cmd_t     reg_info;

    cpld_event_t  exp_events [$];                  // download stream, in order
    reg_cmd_t     exp_cmds [$];                    // register commands, in order
    logic [63:0]  pkt_beats [$];                   // beats of the current row
    logic [31:0]  lfsr_state = 32'h6d6f_d8f9;
    cpld_event_t  cpld_exp;
    reg_cmd_t     want_cmd;
    logic         rd_open  = 1'b0;                 // read issued, no rd_ok yet
    int           ok_delay = 0;
    int           rd_count = 0;

    always #10 PCIE_CLK = ~PCIE_CLK;               // 20 ns period

    pcie_rx UUT (
        .PCIE_CLK    (PCIE_CLK),
        .PCIE_RST    (PCIE_RST),
        .rx_tdata    (rx_tdata),
        .rx_tkeep    (rx_tkeep),
        .rx_tlast    (rx_tlast),
        .rx_tvalid   (rx_tvalid),
        .rx_bar0_hit (rx_bar0_hit),
        .cpld        (cpld),
        .reg_wr_req  (reg_wr_req),
        .reg_rd_req  (reg_rd_req),
        .reg_rd_ok   (reg_rd_ok),
        .reg_addr    (reg_addr),
        .reg_wr_data (reg_wr_data),
        .reg_info    (reg_info)
    );

    // ========================================
    // helpers
    // ========================================
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            stop_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];          // x^32+x^22+x^2+x+1
        return {s[30:0], fb};
    endfunction

    task automatic random_dword(output logic [31:0] value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);    // one step per bit
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // builds the beats of one row and queues what the DUT should answer
    task automatic build_packet(input tlp_row_t row);
        hdr_dw0_t    dw0;
        req_dw1_t    rq;
        cpl_dw1_t    cp;
        logic [31:0] dwords [$];
        logic [31:0] value;
        cpld_event_t ev;
        reg_cmd_t    cmd;
        int          n_pay;
        int          nb;
        dw0      = '0;
        dw0.tc   = row.tc;
        dw0.attr = row.attr;
        dw0.len  = row.len;
        case (row.kind)
            kind_cpld:  dw0.fmt = 7'b100_1010;
            kind_rd:    dw0.fmt = 7'b000_0000;
            kind_req64: dw0.fmt = 7'b110_0000;     // 4dw write
            default:    dw0.fmt = 7'b100_0000;     // 3dw write
        endcase
        rq    = '{req_id: row.id, tag: row.tag, be: row.be};
        cp    = '{cpl_id: row.id, status: 3'd0, bcm: 1'b0, byte_cnt: row.byte_cnt};
        n_pay = (row.kind == kind_rd) ? 0 : int'(row.len);
        dwords.push_back(dw0);
        if (row.kind == kind_cpld) begin
            dwords.push_back(cp);
            dwords.push_back({16'h0001, row.tag, 8'h00}); // requester, tag, lower addr
        end else begin
            dwords.push_back(rq);
            if (row.kind == kind_req64) begin
                dwords.push_back(32'h0000_0001);   // upper address
            end
            dwords.push_back(row.addr);
        end
        for (int i = 0; i < n_pay; i++) begin
            random_dword(value);
            dwords.push_back(value);
        end
        if (dwords.size() % 2 != 0) begin
            dwords.push_back(32'h0);               // pad the last upper half
        end
        pkt_beats.delete();
        for (int i = 0; i < dwords.size(); i += 2) begin
            pkt_beats.push_back({dwords[i+1], dwords[i]});
        end
        nb = pkt_beats.size();
        if (row.kind == kind_cpld) begin
            ev        = '0;
            ev.is_sop = 1'b1;
            ev.tag    = row.tag;
            ev.dcnt   = row.byte_cnt;
            exp_events.push_back(ev);
            for (int k = 2; k < nb; k++) begin     // header and dword 2 beats give no word
                ev      = '0;
                ev.data = {pkt_beats[k-1][63:32], pkt_beats[k][31:0]};
                ev.eop  = (k == nb - 1);
                exp_events.push_back(ev);
            end
        end else if (row.kind == kind_rd || row.kind == kind_wr) begin
            cmd.is_wr   = (row.kind == kind_wr);
            cmd.dw0     = dw0;
            cmd.dw1     = rq;
            cmd.addr    = row.addr;
            cmd.wr_data = swap_bytes(dwords[3]);   // upper dword of beat 1
            exp_cmds.push_back(cmd);
        end
    endtask

    task automatic drive_beat(input logic [63:0] data, input logic last, input logic bar0);
        @(negedge PCIE_CLK);
        rx_tdata    = data;
        rx_tkeep    = 8'hff;
        rx_tlast    = last;
        rx_tvalid   = 1'b1;
        rx_bar0_hit = bar0;
    endtask

    task automatic drive_idle();
        @(negedge PCIE_CLK);
        rx_tdata    = '0;
        rx_tkeep    = '0;
        rx_tlast    = 1'b0;
        rx_tvalid   = 1'b0;
        rx_bar0_hit = 1'b0;
    endtask

    task automatic send_packet(input tlp_row_t row);
        logic bar0;
        int   nb;
        bar0 = (row.kind != kind_cpld) && (row.kind != kind_wr_nbar);
        nb   = pkt_beats.size();
        for (int b = 0; b < nb; b++) begin
            // completion dword 2 has to follow its header beat directly
            if (row.gap && (b >= 2 || (b == 1 && row.kind != kind_cpld))) begin
                drive_idle();
            end
            drive_beat(pkt_beats[b], b == nb - 1, bar0);
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (exp_events.size() != 0 || exp_cmds.size() != 0 || rd_open) begin
            @(negedge PCIE_CLK);
            cycles++;
            if (cycles > drain_timeout) begin
                stop_run("timeout while waiting for the expected outputs to appear");
            end
        end
    endtask

    task automatic check_strobes_low();
        check_value("cpld.sop", 64'(cpld.sop), 64'h0);
        check_value("cpld.dvld", 64'(cpld.dvld), 64'h0);
        check_value("cpld.eop", 64'(cpld.eop), 64'h0);
        check_value("reg_wr_req", 64'(reg_wr_req), 64'h0);
        check_value("reg_rd_req", 64'(reg_rd_req), 64'h0);
    endtask

    // ========================================
    // download stream monitor
    // ========================================
    always @(negedge PCIE_CLK) begin
        if (!PCIE_RST) begin
            if (cpld.eop && !cpld.dvld) begin
                stop_run("completion eop seen without a data word");
            end
            if (cpld.sop) begin
                if (exp_events.size() == 0 || !exp_events[0].is_sop) begin
                    stop_run("completion sop that was not expected");
                end else begin
                    cpld_exp = exp_events.pop_front();
                    check_value("cpld.tag", 64'(cpld.tag), 64'(cpld_exp.tag));
                    check_value("cpld.dcnt", 64'(cpld.dcnt), 64'(cpld_exp.dcnt));
                end
            end
            if (cpld.dvld) begin
                if (exp_events.size() == 0 || exp_events[0].is_sop) begin
                    stop_run("completion data word that was not expected");
                end else begin
                    cpld_exp = exp_events.pop_front();
                    check_value("cpld.data", cpld.data, cpld_exp.data);
                    check_value("cpld.eop", 64'(cpld.eop), 64'(cpld_exp.eop));
                end
            end
        end
    end

    // ========================================
    // register block model and checks
    // ========================================
    always @(negedge PCIE_CLK) begin
        if (!PCIE_RST) begin
            reg_rd_ok = 1'b0;                      // pulse lasts one cycle
            if (reg_wr_req || reg_rd_req) begin
                if (rd_open) begin
                    stop_run("register request issued while a read was still open");
                end else if (exp_cmds.size() == 0) begin
                    stop_run("register request with no command expected");
                end else begin
                    want_cmd = exp_cmds.pop_front();
                    check_value("reg_wr_req", 64'(reg_wr_req), 64'(want_cmd.is_wr));
                    check_value("reg_rd_req", 64'(reg_rd_req), 64'(!want_cmd.is_wr));
                    check_value("reg_addr", 64'(reg_addr), 64'(want_cmd.addr));
                    check_value("reg_wr_data", 64'(reg_wr_data), 64'(want_cmd.wr_data));
                    check_value("reg_info.is_wr", 64'(reg_info.is_wr), 64'(want_cmd.is_wr));
                    check_value("reg_info.dw0", 64'(reg_info.dw0), 64'(want_cmd.dw0));
                    check_value("reg_info.dw1", 64'(reg_info.dw1), 64'(want_cmd.dw1));
                    check_value("reg_info.addr", 64'(reg_info.addr), 64'(want_cmd.addr));
                    check_value("reg_info.wr_data", 64'(reg_info.wr_data),
                                64'(want_cmd.wr_data));
                end
            end
            if (ok_delay != 0) begin
                ok_delay = ok_delay - 1;
                if (ok_delay == 0) begin
                    reg_rd_ok = 1'b1;              // closes the open read
                    rd_open   = 1'b0;
                end
            end
            if (reg_rd_req) begin
                rd_open  = 1'b1;
                ok_delay = 2 + (rd_count % 3);     // answer latency varies
                rd_count = rd_count + 1;
            end
        end
    end

    // ========================================
    // main sequence
    // ========================================
    initial begin
        for (int i = 0; i < 2; i++) begin
            @(posedge PCIE_CLK);
        end
        @(negedge PCIE_CLK);
        PCIE_RST = 1'b0;
        for (int i = 0; i < 8; i++) begin          // strobes stay low while idle
            check_strobes_low();
            @(negedge PCIE_CLK);
        end
        for (int r = 0; r < num_rows; r++) begin
            build_packet(stim_table[r]);
            send_packet(stim_table[r]);
        end
        drive_idle();
        wait_for_drain();
        for (int i = 0; i < idle_tail; i++) begin  // nothing extra may show up
            drive_idle();
        end
        check_strobes_low();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== hdl/pcie_rx.sv ====
// PCIe receive splitter top level
// Completion payload goes to the download stream, BAR0 requests become register commands
// Upstream must treat the stream as always ready

`timescale 1ns/100ps

module pcie_rx (
    input  logic                      PCIE_CLK,
    input  logic                      PCIE_RST,
    input  logic [63:0]               rx_tdata,
    input  logic [7:0]                rx_tkeep,      // interface completeness only
    input  logic                      rx_tlast,
    input  logic                      rx_tvalid,
    input  logic                      rx_bar0_hit,
    output pcie_rx_pkg::cpld_stream_t cpld,
    output logic                      reg_wr_req,
    output logic                      reg_rd_req,
    input  logic                      reg_rd_ok,
    output logic [31:0]               reg_addr,
    output logic [31:0]               reg_wr_data,
    output pcie_rx_pkg::reg_cmd_t     reg_info
);
    import pcie_rx_pkg::*;

    rx_beat_t cur_beat;
    rx_beat_t prev_beat;
    logic     cmd_push;
    reg_cmd_t cmd_word;
    reg_cmd_t fifo_head;
    logic     fifo_empty;
    logic     fifo_pop;

    rx_beat_register u_beat_reg (
        .PCIE_CLK    (PCIE_CLK),
        .PCIE_RST    (PCIE_RST),
        .rx_tdata    (rx_tdata),
        .rx_tlast    (rx_tlast),
        .rx_tvalid   (rx_tvalid),
        .rx_bar0_hit (rx_bar0_hit),
        .cur_beat    (cur_beat),
        .prev_beat   (prev_beat)
    );

    cpld_unpacker u_cpld (
        .PCIE_CLK  (PCIE_CLK),
        .PCIE_RST  (PCIE_RST),
        .cur_beat  (cur_beat),
        .prev_beat (prev_beat),
        .cpld      (cpld)
    );

    mem_req_decoder u_req_dec (
        .PCIE_CLK  (PCIE_CLK),
        .PCIE_RST  (PCIE_RST),
        .cur_beat  (cur_beat),
        .prev_beat (prev_beat),
        .push      (cmd_push),
        .cmd       (cmd_word)
    );

    cmd_fifo u_cmd_fifo (
        .PCIE_CLK (PCIE_CLK),
        .PCIE_RST (PCIE_RST),
        .push     (cmd_push),
        .din      (cmd_word),
        .pop      (fifo_pop),
        .dout     (fifo_head),
        .empty    (fifo_empty)
    );

    reg_cmd_issuer u_issuer (
        .PCIE_CLK    (PCIE_CLK),
        .PCIE_RST    (PCIE_RST),
        .head        (fifo_head),
        .empty       (fifo_empty),
        .pop         (fifo_pop),
        .reg_rd_ok   (reg_rd_ok),
        .reg_wr_req  (reg_wr_req),
        .reg_rd_req  (reg_rd_req),
        .reg_addr    (reg_addr),
        .reg_wr_data (reg_wr_data),
        .reg_info    (reg_info)
    );

endmodule

// ==== hdl/reg_cmd_issuer.sv ====
// Register command issuer
// Pops queued commands at a fixed pace and keeps one register operation outstanding

`timescale 1ns/100ps

module reg_cmd_issuer (
    input  logic                  PCIE_CLK,
    input  logic                  PCIE_RST,
    input  pcie_rx_pkg::reg_cmd_t head,
    input  logic                  empty,
    output logic                  pop,
    input  logic                  reg_rd_ok,
    output logic                  reg_wr_req,
    output logic                  reg_rd_req,
    output logic [31:0]           reg_addr,
    output logic [31:0]           reg_wr_data,
    output pcie_rx_pkg::reg_cmd_t reg_info
);
    import pcie_rx_pkg::*;

    logic [issue_interval-1:0] slot;             // one-hot pacing ring
    logic                      op_busy;          // read or write in flight

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            slot       <= {{(issue_interval-1){1'b0}}, 1'b1};
            op_busy    <= 1'b0;
            pop        <= 1'b0;
            reg_wr_req <= 1'b0;
            reg_rd_req <= 1'b0;
        end else begin
            slot <= {slot[0], slot[issue_interval-1:1]};
            pop  <= slot[0] & ~empty & ~op_busy;
            if (pop) begin
                op_busy <= 1'b1;
            end else if (reg_wr_req || reg_rd_ok) begin
                op_busy <= 1'b0;                 // write closes on its own pulse
            end
            reg_wr_req <= pop & head.is_wr;
            reg_rd_req <= pop & ~head.is_wr;
        end
    end

    // ========================================
    // command fields, held until next request
    // ========================================
    always_ff @(posedge PCIE_CLK) begin
        if (pop) begin
            reg_addr    <= head.addr;
            reg_wr_data <= head.wr_data;
            reg_info    <= head;
        end
    end

    a_one_req: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        !(reg_wr_req && reg_rd_req));

endmodule

// ==== hdl/cmd_fifo.sv ====
// Register command queue
// Small first-word-fall-through FIFO, the head word is valid whenever empty is low

`timescale 1ns/100ps

module cmd_fifo (
    input  logic                  PCIE_CLK,
    input  logic                  PCIE_RST,
    input  logic                  push,
    input  pcie_rx_pkg::reg_cmd_t din,
    input  logic                  pop,
    output pcie_rx_pkg::reg_cmd_t dout,
    output logic                  empty
);
    import pcie_rx_pkg::*;

    reg_cmd_t               mem [cmd_fifo_depth];
    logic [cmd_fifo_aw-1:0] wr_ptr;
    logic [cmd_fifo_aw-1:0] rd_ptr;
    logic [cmd_fifo_aw:0]   count;
    logic                   full;

    assign full  = (count == (cmd_fifo_aw + 1)'(cmd_fifo_depth));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];                  // fall-through head

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;         // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge PCIE_CLK) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    a_no_overrun: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        !(push && full) && !(pop && empty));

endmodule

// ==== hdl/mem_req_decoder.sv ====
// BAR0 memory request decoder
// Turns each 32-bit-address memory read or write hitting BAR0 into one register command

`timescale 1ns/100ps

module mem_req_decoder (
    input  logic                  PCIE_CLK,
    input  logic                  PCIE_RST,
    input  pcie_rx_pkg::rx_beat_t cur_beat,
    input  pcie_rx_pkg::rx_beat_t prev_beat,
    output logic                  push,
    output pcie_rx_pkg::reg_cmd_t cmd
);
    import pcie_rx_pkg::*;

    hdr_dw0_t cur_dw0;
    hdr_dw0_t hdr_dw0;                           // header beat, now on prev
    hdr_dw1_u hdr_dw1;
    logic     req_hit;
    logic     addr_pend;                         // next valid beat holds the address
    logic     addr_take;
    logic     asm_vld;
    reg_cmd_t asm_cmd;

    assign cur_dw0   = cur_beat.data[31:0];
    assign hdr_dw0   = prev_beat.data[31:0];
    assign hdr_dw1   = prev_beat.data[63:32];
    assign req_hit   = cur_beat.sop && cur_beat.bar0_hit &&
                       (cur_dw0.fmt[5:0] == fmt_mem_rw32);
    assign addr_take = addr_pend && cur_beat.valid;

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            addr_pend <= 1'b0;
            asm_vld   <= 1'b0;
            push      <= 1'b0;
        end else begin
            if (req_hit) begin
                addr_pend <= 1'b1;
            end else if (cur_beat.valid) begin
                addr_pend <= 1'b0;
            end
            asm_vld <= addr_take;
            push    <= asm_vld;                  // single cycle per packet
        end
    end

    // ========================================
    // command assembly
    // ========================================
    always_ff @(posedge PCIE_CLK) begin
        if (addr_take) begin
            asm_cmd.is_wr   <= hdr_dw0.fmt[wr_flag_bit];
            asm_cmd.dw0     <= hdr_dw0;
            asm_cmd.dw1     <= hdr_dw1.req;      // request view of dword 1
            asm_cmd.addr    <= cur_beat.data[31:0];
            asm_cmd.wr_data <= {<<8{cur_beat.data[63:32]}}; // byte swap
        end
        if (asm_vld) begin
            cmd <= asm_cmd;
        end
    end

endmodule

// ==== hdl/cpld_unpacker.sv ====
// Completion-with-data unpacker
// Strips the 3-DW header, captures tag and byte count, realigns payload to 64-bit words

`timescale 1ns/100ps

module cpld_unpacker (
    input  logic                      PCIE_CLK,
    input  logic                      PCIE_RST,
    input  pcie_rx_pkg::rx_beat_t     cur_beat,
    input  pcie_rx_pkg::rx_beat_t     prev_beat,
    output pcie_rx_pkg::cpld_stream_t cpld
);
    import pcie_rx_pkg::*;

    hdr_dw0_t    dw0;
    hdr_dw1_u    dw1;
    logic        hdr_hit;
    logic        sop_d1;
    logic        sop_d2;
    logic        tag_pend;                       // waiting for the dword 2 beat
    logic        in_pkt;                         // payload beats follow
    logic [7:0]  tag_q;
    logic [11:0] dcnt_q;
    logic        dvld_d1;
    logic        dvld_d2;
    logic        eop_d1;
    logic        eop_d2;
    logic [63:0] word_d1;
    logic [63:0] word_d2;
    logic        out_sop;
    logic        out_eop;
    logic        out_dvld;
    logic [63:0] out_data;
    logic [7:0]  out_tag;
    logic [11:0] out_dcnt;
    logic        out_open;                       // between output sop and eop

    assign dw0     = cur_beat.data[31:0];
    assign dw1     = cur_beat.data[63:32];
    assign hdr_hit = cur_beat.sop && (dw0.fmt == fmt_cpld);

    // ========================================
    // header tracking and strobe pipeline
    // ========================================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            sop_d1   <= 1'b0;
            sop_d2   <= 1'b0;
            tag_pend <= 1'b0;
            in_pkt   <= 1'b0;
            dvld_d1  <= 1'b0;
            dvld_d2  <= 1'b0;
            eop_d1   <= 1'b0;
            eop_d2   <= 1'b0;
            out_sop  <= 1'b0;
            out_eop  <= 1'b0;
            out_dvld <= 1'b0;
            out_open <= 1'b0;
        end else begin
            sop_d1 <= hdr_hit;
            sop_d2 <= sop_d1;
            if (hdr_hit) begin
                tag_pend <= 1'b1;
                in_pkt   <= 1'b0;
            end else if (cur_beat.valid && tag_pend) begin
                tag_pend <= 1'b0;                // dword 2 and first data dword
                in_pkt   <= ~cur_beat.eop;
            end else if (cur_beat.valid && cur_beat.eop) begin
                in_pkt   <= 1'b0;
            end
            dvld_d1  <= cur_beat.valid & in_pkt;
            eop_d1   <= cur_beat.valid & cur_beat.eop & in_pkt;
            dvld_d2  <= dvld_d1;
            eop_d2   <= eop_d1;
            out_sop  <= sop_d2;
            out_dvld <= dvld_d2;
            out_eop  <= eop_d2;
            if (out_sop) begin
                out_open <= 1'b1;
            end else if (out_eop) begin
                out_open <= 1'b0;
            end
        end
    end

    // ========================================
    // payload path
    // ========================================
    always_ff @(posedge PCIE_CLK) begin
        if (hdr_hit) begin
            dcnt_q <= dw1.cpl.byte_cnt;          // completion view of dword 1
        end
        if (cur_beat.valid && tag_pend) begin
            tag_q <= cur_beat.data[15:8];        // tag sits in dword 2
        end
        word_d1  <= {prev_beat.data[63:32], cur_beat.data[31:0]}; // prev hi on top
        word_d2  <= word_d1;
        out_data <= word_d2;
        if (sop_d2) begin
            out_tag  <= tag_q;                   // held until next sop
            out_dcnt <= dcnt_q;
        end
    end

    assign cpld = '{sop: out_sop, eop: out_eop, dvld: out_dvld, data: out_data,
                    tag: out_tag, dcnt: out_dcnt};

    a_dvld_in_pkt: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        cpld.dvld |-> out_open);

endmodule

// ==== hdl/rx_beat_register.sv ====
// Receive stream input register
// Registers each AXI-Stream beat with sop/eop flags and keeps the last valid beat

`timescale 1ns/100ps

module rx_beat_register (
    input  logic                  PCIE_CLK,
    input  logic                  PCIE_RST,
    input  logic [63:0]           rx_tdata,
    input  logic                  rx_tlast,
    input  logic                  rx_tvalid,
    input  logic                  rx_bar0_hit,
    output pcie_rx_pkg::rx_beat_t cur_beat,
    output pcie_rx_pkg::rx_beat_t prev_beat
);
    import pcie_rx_pkg::*;

    logic        first_beat;                     // next valid beat starts a packet
    logic        cur_vld;
    logic        cur_sop;
    logic        cur_eop;
    logic        cur_bar0;
    logic [63:0] cur_data;
    logic        prev_vld;
    logic        prev_sop;
    logic        prev_eop;
    logic        prev_bar0;
    logic [63:0] prev_data;

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            first_beat <= 1'b1;
            cur_vld    <= 1'b0;
            cur_sop    <= 1'b0;
            cur_eop    <= 1'b0;
            cur_bar0   <= 1'b0;
            prev_vld   <= 1'b0;
            prev_sop   <= 1'b0;
            prev_eop   <= 1'b0;
            prev_bar0  <= 1'b0;
        end else begin
            if (rx_tvalid) begin
                first_beat <= rx_tlast;          // beat after tlast is a new sop
            end
            cur_vld  <= rx_tvalid;
            cur_sop  <= rx_tvalid & first_beat;
            cur_eop  <= rx_tvalid & rx_tlast;
            cur_bar0 <= rx_bar0_hit;
            if (cur_vld) begin                   // idle cycles leave prev alone
                prev_vld  <= 1'b1;
                prev_sop  <= cur_sop;
                prev_eop  <= cur_eop;
                prev_bar0 <= cur_bar0;
            end
        end
    end

    always_ff @(posedge PCIE_CLK) begin
        cur_data <= rx_tdata;
        if (cur_vld) begin
            prev_data <= cur_data;
        end
    end

    assign cur_beat  = '{valid: cur_vld, sop: cur_sop, eop: cur_eop,
                         bar0_hit: cur_bar0, data: cur_data};
    assign prev_beat = '{valid: prev_vld, sop: prev_sop, eop: prev_eop,
                         bar0_hit: prev_bar0, data: prev_data};

    a_flags_need_valid: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        (cur_beat.sop || cur_beat.eop) |-> cur_beat.valid);

endmodule

// ==== hdl/pcie_rx_pkg.sv ====
// PCIe receive splitter shared definitions
// TLP format codes, header dword layouts, stream beat and register command types

package pcie_rx_pkg;

    // ========================================
    // tlp decode constants
    // ========================================
    localparam logic [5:0] fmt_mem_rw32   = 6'b00_0000;        // 3dw mem rd/wr, wr bit not compared
    localparam logic [6:0] fmt_cpld       = 7'b100_1010;       // completion with data
    localparam int         wr_flag_bit    = 6;                 // fmt bit set for writes

    localparam int         cmd_fifo_depth = 16;                // queued register commands
    localparam int         cmd_fifo_aw    = $clog2(cmd_fifo_depth);
    localparam int         issue_interval = 3;                 // cycles between pop chances

    // ========================================
    // stream and header types
    // ========================================
    typedef struct packed {
        logic        valid;
        logic        sop;
        logic        eop;
        logic        bar0_hit;
        logic [63:0] data;
    } rx_beat_t;

    // header dword 0, bit 31 on the left
    typedef struct packed {
        logic       rsvd0;
        logic [6:0] fmt;        // fmt and type
        logic       rsvd1;
        logic [2:0] tc;
        logic [3:0] rsvd2;
        logic       td;
        logic       ep;
        logic [1:0] attr;
        logic [1:0] rsvd3;
        logic [9:0] len;        // length in dwords
    } hdr_dw0_t;

    typedef struct packed {
        logic [15:0] req_id;
        logic [7:0]  tag;
        logic [7:0]  be;        // last and first byte enables
    } req_dw1_t;

    typedef struct packed {
        logic [15:0] cpl_id;
        logic [2:0]  status;
        logic        bcm;
        logic [11:0] byte_cnt;
    } cpl_dw1_t;

    // dword 1 means different things for requests and completions
    typedef union packed {
        req_dw1_t req;
        cpl_dw1_t cpl;
    } hdr_dw1_u;

    typedef struct packed {
        logic        sop;
        logic        eop;
        logic        dvld;
        logic [63:0] data;
        logic [7:0]  tag;
        logic [11:0] dcnt;
    } cpld_stream_t;

    typedef struct packed {
        logic        is_wr;
        hdr_dw0_t    dw0;
        req_dw1_t    dw1;
        logic [31:0] addr;
        logic [31:0] wr_data;
    } reg_cmd_t;

endpackage
